// ==== source/stream_pkg.sv ====
// stream buffer shared definitions
// widths and depths of the packet stream buffer, the beat layout
// and the read states of the block RAM fifo

package stream_pkg;

   // payload width of one beat
   localparam int DATA_WIDTH = 32;

   // stored beat carries the payload plus the last-of-packet flag
   localparam int BEAT_WIDTH = DATA_WIDTH + 1;

   // log2 depth of the main block RAM store, 512 lines
   localparam int MAIN_SIZE = 9;

   // log2 depth of the ingress register fifo, 32 entries
   localparam int INGRESS_SIZE = 5;

   // width of the diagnostic space and occupied counts
   localparam int COUNT_WIDTH = 16;

   // one stream beat, data in the upper bits and last in bit 0
   typedef struct packed
   {
      logic [DATA_WIDTH-1:0] data;
      logic                  last;
   } stream_beat_t;

   // read side of the block RAM fifo
   // pre-read fetches the head line so it is presented from the RAM register
   typedef enum logic [1:0]
   {
      RD_EMPTY    = 2'd0,
      RD_PRE_READ = 2'd1,
      RD_READING  = 2'd2
   } read_state_t;

endpackage

// ==== source/ram_2port.sv ====
// simple dual-port block RAM
// one write port and one read port with an enable on the output register,
// the read data holds its value while the enable is low

module ram_2port
   import stream_pkg::*;
#(
   parameter int DWIDTH = BEAT_WIDTH,
   parameter int AWIDTH = MAIN_SIZE
)
(
   input  logic              clk,
   input  logic              i_we,
   input  logic [AWIDTH-1:0] i_wr_addr,
   input  logic [DWIDTH-1:0] i_wr_data,
   input  logic              i_rd_en,
   input  logic [AWIDTH-1:0] i_rd_addr,
   output logic [DWIDTH-1:0] o_rd_data
);

   logic [DWIDTH-1:0] mem [0:(1<<AWIDTH)-1];

   // write port
   always_ff @(posedge clk)
   begin
      if (i_we)
      begin
         mem[i_wr_addr] <= i_wr_data;
      end
   end

   // registered read, output holds when not enabled
   always_ff @(posedge clk)
   begin
      if (i_rd_en)
      begin
         o_rd_data <= mem[i_rd_addr];
      end
   end

endmodule

// ==== source/axi_fifo_short.sv ====
// short register fifo on a valid/ready stream
// shift register addressed by a fill pointer, new beats enter at entry 0
// and the oldest beat sits at fill-1

module axi_fifo_short
   import stream_pkg::*;
#(
   parameter int WIDTH = BEAT_WIDTH,
   parameter int SIZE  = INGRESS_SIZE
)
(
   input  logic             clk,
   input  logic             reset,
   input  logic             i_clear,
   input  logic [WIDTH-1:0] i_tdata,
   input  logic             i_tvalid,
   output logic             o_tready_in,
   output logic [WIDTH-1:0] o_tdata,
   output logic             o_tvalid,
   input  logic             i_tready,
   output logic [SIZE:0]    o_space,
   output logic [SIZE:0]    o_occupied
);

   logic [WIDTH-1:0] mem [0:(1<<SIZE)-1];
   logic [SIZE:0]    fill;
   logic [SIZE-1:0]  head_idx;
   logic             full;
   logic             empty;
   logic             write;
   logic             read;

   // fill only reaches the top bit when every entry is held
   assign full  = fill[SIZE];
   assign empty = (fill == '0);

   assign o_tready_in = ~full;
   assign o_tvalid    = ~empty;

   assign write = i_tvalid & o_tready_in;
   assign read  = o_tvalid & i_tready;

   // wraps to the last entry when full
   assign head_idx = fill[SIZE-1:0] - 1'b1;
   assign o_tdata  = mem[head_idx];

   assign o_occupied = fill;
   assign o_space    = (SIZE+1)'(1 << SIZE) - fill;

   // every write shifts the whole array by one entry
   always_ff @(posedge clk)
   begin
      if (write)
      begin
         mem[0] <= i_tdata;
         for (int i = 1; i < (1 << SIZE); i++)
         begin
            mem[i] <= mem[i-1];
         end
      end
   end

   // fill pointer, unchanged on a simultaneous read and write
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         fill <= '0;
      end
      else if (write && !read)
      begin
         fill <= fill + 1'b1;
      end
      else if (read && !write)
      begin
         fill <= fill - 1'b1;
      end
   end

   // a full fifo stays full until a beat leaves
   a_no_write_when_full : assert property (@(posedge clk) disable iff (reset || i_clear)
      full && !read |=> full && fill == $past(fill));

endmodule

// ==== source/axi_fifo.sv ====
// block RAM fifo on a valid/ready stream
// a read-ahead state machine fetches the head line so the output comes
// straight from the RAM register; depths of 32 or less use the register fifo
// space and occupied are diagnostic counts

module axi_fifo
   import stream_pkg::*;
#(
   parameter int WIDTH = BEAT_WIDTH,
   parameter int SIZE  = MAIN_SIZE
)
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   i_clear,
   input  logic [WIDTH-1:0]       i_tdata,
   input  logic                   i_tvalid,
   output logic                   o_tready_in,
   output logic [WIDTH-1:0]       o_tdata,
   output logic                   o_tvalid,
   input  logic                   i_tready,
   output logic [COUNT_WIDTH-1:0] o_space,
   output logic [COUNT_WIDTH-1:0] o_occupied
);

   generate
      if (SIZE <= 5)
      begin : g_short
         logic [SIZE:0] space_short;
         logic [SIZE:0] occupied_short;

         axi_fifo_short #(
            .WIDTH (WIDTH),
            .SIZE  (SIZE)
         ) u_fifo_short (
            .clk         (clk),
            .reset       (reset),
            .i_clear     (i_clear),
            .i_tdata     (i_tdata),
            .i_tvalid    (i_tvalid),
            .o_tready_in (o_tready_in),
            .o_tdata     (o_tdata),
            .o_tvalid    (o_tvalid),
            .i_tready    (i_tready),
            .o_space     (space_short),
            .o_occupied  (occupied_short)
         );

         assign o_space    = COUNT_WIDTH'(space_short);
         assign o_occupied = COUNT_WIDTH'(occupied_short);
      end
      else
      begin : g_bram
         logic [SIZE-1:0] wr_addr;
         logic [SIZE-1:0] rd_addr;
         logic [SIZE-1:0] guard_addr;
         read_state_t     read_state;
         logic            empty_reg;
         logic            full_reg;
         logic            write;
         logic            read;
         logic            becoming_full;

         assign write = i_tvalid & o_tready_in;
         assign read  = o_tvalid & i_tready;

         assign o_tready_in = ~full_reg;
         assign o_tvalid    = ~empty_reg;

         always_ff @(posedge clk)
         begin
            if (reset || i_clear)
            begin
               wr_addr <= '0;
            end
            else if (write)
            begin
               wr_addr <= wr_addr + 1'b1;
            end
         end

         // the RAM register only advances on a pre-read or an accepted beat
         ram_2port #(
            .DWIDTH (WIDTH),
            .AWIDTH (SIZE)
         ) u_ram (
            .clk       (clk),
            .i_we      (write),
            .i_wr_addr (wr_addr),
            .i_wr_data (i_tdata),
            .i_rd_en   ((read_state == RD_PRE_READ) | read),
            .i_rd_addr (rd_addr),
            .o_rd_data (o_tdata)
         );

         // rd_addr runs one line ahead of the beat on o_tdata
         always_ff @(posedge clk)
         begin
            if (reset || i_clear)
            begin
               read_state <= RD_EMPTY;
               rd_addr    <= '0;
               empty_reg  <= 1'b1;
            end
            else
            begin
               case (read_state)
                  RD_EMPTY:
                  begin
                     if (write)
                     begin
                        read_state <= RD_PRE_READ;
                     end
                  end
                  RD_PRE_READ:
                  begin
                     read_state <= RD_READING;
                     empty_reg  <= 1'b0;
                     rd_addr    <= rd_addr + 1'b1;
                  end
                  RD_READING:
                  begin
                     if (read)
                     begin
                        if (rd_addr == wr_addr)
                        begin
                           // last stored line just left
                           empty_reg  <= 1'b1;
                           read_state <= write ? RD_PRE_READ : RD_EMPTY;
                        end
                        else
                        begin
                           rd_addr <= rd_addr + 1'b1;
                        end
                     end
                  end
                  default:
                  begin
                     read_state <= RD_EMPTY;
                  end
               endcase
            end
         end

         // keep two lines between the pointers so the pre-read line is never overwritten
         assign guard_addr    = rd_addr - SIZE'(2);
         assign becoming_full = (wr_addr == guard_addr);

         always_ff @(posedge clk)
         begin
            if (reset || i_clear)
            begin
               full_reg <= 1'b0;
            end
            else if (read && !write)
            begin
               full_reg <= 1'b0;
            end
            else if (write && !read && becoming_full)
            begin
               full_reg <= 1'b1;
            end
         end

         // diagnostic counts, approximate near full
         always_ff @(posedge clk)
         begin
            if (reset || i_clear)
            begin
               o_space    <= COUNT_WIDTH'(1 << SIZE);
               o_occupied <= '0;
            end
            else if (read && !write)
            begin
               o_space    <= o_space + COUNT_WIDTH'(1);
               o_occupied <= o_occupied - COUNT_WIDTH'(1);
            end
            else if (write && !read)
            begin
               o_space    <= o_space - COUNT_WIDTH'(1);
               o_occupied <= o_occupied + COUNT_WIDTH'(1);
            end
         end

         a_state_legal : assert property (@(posedge clk) disable iff (reset)
            read_state inside {RD_EMPTY, RD_PRE_READ, RD_READING});

         // a presented beat holds until it is taken
         a_data_stable : assert property (@(posedge clk) disable iff (reset || i_clear)
            o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata));
      end
   endgenerate

endmodule

// ==== source/packet_gate.sv ====
// packet gate on the output of the main store
// counts complete packets held in the store and opens the path only while
// one is present, so a released packet never stalls for lack of data

module packet_gate
   import stream_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         i_clear,
   input  logic         i_store_write,
   input  logic         i_store_last,
   input  stream_beat_t i_beat,
   input  logic         i_valid,
   output logic         o_ready,
   output stream_beat_t o_beat,
   output logic         o_valid,
   input  logic         i_ready
);

   logic [COUNT_WIDTH-1:0] pkt_count;
   logic                   gate_open;
   logic                   pkt_in;
   logic                   pkt_out;

   // a packet is complete once its last beat is written into the store
   assign pkt_in = i_store_write & i_store_last;

   // and leaves when its last beat is released
   assign pkt_out = o_valid & i_ready & o_beat.last;

   assign gate_open = (pkt_count != '0);

   assign o_beat  = i_beat;
   assign o_valid = i_valid & gate_open;
   assign o_ready = i_ready & gate_open;

   // arrival and departure in the same cycle cancel out
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         pkt_count <= '0;
      end
      else if (pkt_in && !pkt_out)
      begin
         pkt_count <= pkt_count + COUNT_WIDTH'(1);
      end
      else if (pkt_out && !pkt_in)
      begin
         pkt_count <= pkt_count - COUNT_WIDTH'(1);
      end
   end

   // count never wraps below zero
   a_no_underflow : assert property (@(posedge clk) disable iff (reset || i_clear)
      pkt_count == '0 && !pkt_in |=> pkt_count == '0);

endmodule

// ==== source/stream_buffer.sv ====
// packet stream buffer
// ingress register fifo, block RAM main store and packet gate in a chain,
// beats leave only as whole stored packets

module stream_buffer
   import stream_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   i_clear,
   input  logic [DATA_WIDTH-1:0]  i_tdata,
   input  logic                   i_tlast,
   input  logic                   i_tvalid,
   output logic                   o_in_ready,
   output logic [DATA_WIDTH-1:0]  o_tdata,
   output logic                   o_tlast,
   output logic                   o_tvalid,
   input  logic                   i_out_ready,
   output logic [COUNT_WIDTH-1:0] o_space,
   output logic [COUNT_WIDTH-1:0] o_occupied
);

   stream_beat_t in_beat;
   stream_beat_t ing_beat;
   stream_beat_t main_beat;
   stream_beat_t out_beat;
   logic         ing_valid;
   logic         main_ready;
   logic         main_valid;
   logic         gate_ready;

   assign in_beat.data = i_tdata;
   assign in_beat.last = i_tlast;

   axi_fifo_short #(
      .WIDTH (BEAT_WIDTH),
      .SIZE  (INGRESS_SIZE)
   ) u_ingress (
      .clk         (clk),
      .reset       (reset),
      .i_clear     (i_clear),
      .i_tdata     (in_beat),
      .i_tvalid    (i_tvalid),
      .o_tready_in (o_in_ready),
      .o_tdata     (ing_beat),
      .o_tvalid    (ing_valid),
      .i_tready    (main_ready),
      .o_space     (),
      .o_occupied  ()
   );

   axi_fifo #(
      .WIDTH (BEAT_WIDTH),
      .SIZE  (MAIN_SIZE)
   ) u_main (
      .clk         (clk),
      .reset       (reset),
      .i_clear     (i_clear),
      .i_tdata     (ing_beat),
      .i_tvalid    (ing_valid),
      .o_tready_in (main_ready),
      .o_tdata     (main_beat),
      .o_tvalid    (main_valid),
      .i_tready    (gate_ready),
      .o_space     (o_space),
      .o_occupied  (o_occupied)
   );

   // the gate watches the store's write handshake to count stored packet ends
   packet_gate u_gate (
      .clk           (clk),
      .reset         (reset),
      .i_clear       (i_clear),
      .i_store_write (ing_valid & main_ready),
      .i_store_last  (ing_beat.last),
      .i_beat        (main_beat),
      .i_valid       (main_valid),
      .o_ready       (gate_ready),
      .o_beat        (out_beat),
      .o_valid       (o_tvalid),
      .i_ready       (i_out_ready)
   );

   assign o_tdata = out_beat.data;
   assign o_tlast = out_beat.last;

endmodule

// ==== test/stream_buffer_tb.sv ====
// self-checking testbench for the packet stream buffer
// commands and expected beats come from the stimulus file
// output ready is randomized and every released beat is checked against the expected queue

module stream_buffer_tb
   import stream_pkg::*;
();

   logic                   clk;
   logic                   reset;
   logic                   i_clear;
   logic [DATA_WIDTH-1:0]  i_tdata;
   logic                   i_tlast;
   logic                   i_tvalid;
   logic                   o_in_ready;
   logic [DATA_WIDTH-1:0]  o_tdata;
   logic                   o_tlast;
   logic                   o_tvalid;
   logic                   i_out_ready;
   logic [COUNT_WIDTH-1:0] o_space;
   logic [COUNT_WIDTH-1:0] o_occupied;

   stream_beat_t           send_q[$];
   stream_beat_t           expect_q[$];
   stream_beat_t           next_beat;
   stream_beat_t           exp_beat;
   integer                 seed = 69;
   integer                 rnd;
   integer                 stall_left = 0;
   integer                 mismatch_count = 0;
   integer                 other_count = 0;
   integer                 fd;
   integer                 line_count;
   integer                 timeout_cycles;
   integer                 scan_n;
   integer                 field_a;
   integer                 field_b;
   logic [31:0]            field_data;
   reg [8*16-1:0]          cmd;
   reg [8*256-1:0]         line;

   stream_buffer DUT (
      .clk         (clk),
      .reset       (reset),
      .i_clear     (i_clear),
      .i_tdata     (i_tdata),
      .i_tlast     (i_tlast),
      .i_tvalid    (i_tvalid),
      .o_in_ready  (o_in_ready),
      .o_tdata     (o_tdata),
      .o_tlast     (o_tlast),
      .o_tvalid    (o_tvalid),
      .i_out_ready (i_out_ready),
      .o_space     (o_space),
      .o_occupied  (o_occupied)
   );

   always #2 clk = ~clk;

   // the next input beat is presented once the current one is taken
   always @(posedge clk)
   begin
      if (!reset && (!i_tvalid || o_in_ready))
      begin
         if (send_q.size() != 0)
         begin
            next_beat = send_q.pop_front();
            i_tdata  <= next_beat.data;
            i_tlast  <= next_beat.last;
            i_tvalid <= 1'b1;
         end
         else
         begin
            i_tvalid <= 1'b0;
         end
      end
   end

   // output ready is held low during a stall and is high about 3 cycles in 4 otherwise
   always @(posedge clk)
   begin
      if (reset || stall_left > 0)
      begin
         i_out_ready <= 1'b0;
         if (stall_left > 0)
         begin
            stall_left = stall_left - 1;
         end
      end
      else
      begin
         rnd = $random(seed);
         i_out_ready <= (rnd[1:0] != 2'b00);
      end
   end

   // a beat is taken at the next rising edge when valid and ready are both high
   always @(negedge clk)
   begin
      if (!reset && o_tvalid && i_out_ready)
      begin
         assert (expect_q.size() != 0)
         else
         begin
            other_count++;
            $display("output beat %h appeared while no beat was expected", o_tdata);
         end
         if (expect_q.size() != 0)
         begin
            exp_beat = expect_q.pop_front();
            assert (o_tdata == exp_beat.data)
            else
            begin
               mismatch_count++;
               $display("mismatch o_tdata: got %h expected %h", o_tdata, exp_beat.data);
            end
            assert (o_tlast == exp_beat.last)
            else
            begin
               mismatch_count++;
               $display("mismatch o_tlast: got %h expected %h", o_tlast, exp_beat.last);
            end
         end
      end
   end

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0)
      begin
         $display("all tests passed");
      end
      else
      begin
         $display("tests failed");
      end
      $finish;
   endtask

   task automatic queue_packet(input int beats, input logic [31:0] base, input bit expect_out);
      stream_beat_t beat;
      for (int i = 0; i < beats; i++)
      begin
         beat.data = base + i;
         beat.last = (i == beats - 1);
         send_q.push_back(beat);
         if (expect_out)
         begin
            expect_q.push_back(beat);
         end
      end
   endtask

   task automatic wait_input_drained();
      while (send_q.size() != 0 || i_tvalid)
      begin
         @(negedge clk);
      end
   endtask

   // the output must stay quiet once all expected beats are released
   task automatic check_output_quiet(input int cycles);
      bit reported;
      reported = 1'b0;
      wait_input_drained();
      while (expect_q.size() != 0)
      begin
         @(negedge clk);
      end
      repeat (cycles)
      begin
         @(negedge clk);
         assert (!o_tvalid || reported)
         else
         begin
            other_count++;
            reported = 1'b1;
            $display("output valid raised while no complete packet was stored");
         end
      end
   endtask

   // with the input drained the ingress fifo has room again
   task automatic check_counts(input int occupied, input int space);
      int waited;
      waited = 0;
      wait_input_drained();
      while ((o_occupied != occupied || o_space != space) && waited < 200)
      begin
         @(negedge clk);
         waited++;
      end
      assert (o_occupied == occupied)
      else
      begin
         mismatch_count++;
         $display("mismatch o_occupied: got %h expected %h", o_occupied, occupied);
      end
      assert (o_space == space)
      else
      begin
         mismatch_count++;
         $display("mismatch o_space: got %h expected %h", o_space, space);
      end
      assert (o_in_ready == 1'b1)
      else
      begin
         mismatch_count++;
         $display("mismatch o_in_ready: got %h expected %h", o_in_ready, 1'b1);
      end
   endtask

   task automatic pulse_clear();
      wait_input_drained();
      @(posedge clk);
      i_clear <= 1'b1;
      @(posedge clk);
      i_clear <= 1'b0;
      @(negedge clk);
   endtask

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      i_clear     = 1'b0;
      i_tdata     = '0;
      i_tlast     = 1'b0;
      i_tvalid    = 1'b0;
      i_out_ready = 1'b0;
      line_count  = 0;
      fd = $fopen("test/stream_buffer_input.txt", "r");
      if (fd == 0)
      begin
         other_count++;
         $display("could not open the stimulus file test/stream_buffer_input.txt");
         finish_run();
      end
      else
      begin
         while (!$feof(fd))
         begin
            if ($fgets(line, fd) > 0)
            begin
               line_count++;
            end
         end
         $fclose(fd);
         fd = $fopen("test/stream_buffer_input.txt", "r");
         timeout_cycles = 200 * line_count;

         // watchdog
         fork
            begin
               repeat (timeout_cycles) @(posedge clk);
               other_count++;
               $display("run did not finish within %0d cycles", timeout_cycles);
               finish_run();
            end
         join_none

         repeat (8) @(posedge clk);
         reset <= 1'b0;
         @(negedge clk);

         while ($fscanf(fd, "%s", cmd) == 1)
         begin
            case (cmd)
               "#":
               begin
                  scan_n = $fgets(line, fd);
               end
               "SEND", "EXPECT":
               begin
                  scan_n = $fscanf(fd, "%h %d", field_data, field_b);
                  next_beat.data = field_data;
                  next_beat.last = (field_b != 0);
                  if (cmd == "SEND")
                  begin
                     send_q.push_back(next_beat);
                  end
                  else
                  begin
                     expect_q.push_back(next_beat);
                  end
               end
               "PACKET", "DROP":
               begin
                  scan_n = $fscanf(fd, "%d %h", field_a, field_data);
                  queue_packet(field_a, field_data, cmd == "PACKET");
               end
               "STALL":
               begin
                  scan_n = $fscanf(fd, "%d", field_a);
                  @(negedge clk);
                  stall_left = field_a;
               end
               "HOLD":
               begin
                  scan_n = $fscanf(fd, "%d", field_a);
                  check_output_quiet(field_a);
               end
               "CLEAR":
               begin
                  pulse_clear();
               end
               "COUNT":
               begin
                  scan_n = $fscanf(fd, "%d %d", field_a, field_b);
                  check_counts(field_a, field_b);
               end
               default:
               begin
                  other_count++;
                  $display("unknown command %0s in the stimulus file", cmd);
               end
            endcase
         end
         $fclose(fd);

         // every queued beat must leave before the run ends
         wait_input_drained();
         while (expect_q.size() != 0)
         begin
            @(negedge clk);
         end
         repeat (20) @(negedge clk);
         finish_run();
      end
   end

endmodule

// ==== stream_buffer.f ====
source/stream_pkg.sv
source/ram_2port.sv
source/axi_fifo_short.sv
source/axi_fifo.sv
source/packet_gate.sv
source/stream_buffer.sv
test/stream_buffer_tb.sv

// ==== test/stream_buffer_input.txt ====
# columns: command then fields, data and base in hex, the rest in decimal
# SEND/EXPECT data last, PACKET/DROP beats base, STALL/HOLD cycles, COUNT occupied space
SEND 00000011 1
EXPECT 00000011 1
SEND 00000021 0
SEND 00000022 1
EXPECT 00000021 0
EXPECT 00000022 1
PACKET 5 00002000
PACKET 40 00003000
SEND a0000001 0
SEND a0000002 0
SEND a0000003 0
HOLD 50
SEND a0000004 1
EXPECT a0000001 0
EXPECT a0000002 0
EXPECT a0000003 0
EXPECT a0000004 1
PACKET 64 00004000
PACKET 7 00005000
HOLD 1
STALL 2000
PACKET 10 00006000
PACKET 6 00007000
COUNT 16 496
STALL 0
HOLD 1
STALL 3000
DROP 12 dead0000
COUNT 12 500
CLEAR
COUNT 0 512
STALL 0
PACKET 4 00008000
PACKET 1 00009000
